// ==== compile.f ====
+incdir+.
cdc_beat_pkg.sv
cdc_ctrl_pkg.sv
cdc_gray_sync.sv
cdc_ram_flops.sv
cdc_fifo_ctrl.sv
cdc_fifo_flops.sv
cdc_push_arbiter.sv
cdc_mux_crossing.sv
tb_cdc_mux_crossing.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the crossing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cdc_mux_crossing \
  --Mdir obj_dir -o sim_tb \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator compile step failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench verdict lives in the log
if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== tb_cdc_mux_crossing.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

module tb_cdc_mux_crossing
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
();

  localparam int WORDS       = 200;
  localparam int START_LIMIT = 50;
  localparam int FULL_LIMIT  = 200;
  localparam int RECV_LIMIT  = 20000;
  localparam int DRAIN_LIMIT = 200;

  logic                       push_clk;
  logic                       pop_clk;
  logic                       rst_n;
  logic                       in_a_valid;
  logic [`CDC_DATA_WIDTH-1:0] in_a_data;
  logic                       in_a_ready;
  logic                       in_b_valid;
  logic [`CDC_DATA_WIDTH-1:0] in_b_data;
  logic                       in_b_ready;
  logic                       pop_ready;
  logic                       pop_valid;
  cdc_beat_t                  pop_beat;
  logic                       push_full;
  fifo_cnt_t                  push_slots;
  logic                       pop_empty;
  fifo_cnt_t                  pop_items;

  // Stimulus controls, changed by the main sequence
  logic      prod_en;
  logic      rand_gate;
  logic      pop_hold;

  integer    seed = 53;
  int        errors = 0;
  int        timeouts = 0;
  int        sent_a = 0;
  int        sent_b = 0;
  int        recv [2];
  // Reset leaves priority with A, as if B had won last
  src_id_e   last_src = SRC_B;
  logic      held_check = 1'b0;
  cdc_beat_t held_beat;

  cdc_mux_crossing UUT (
    .push_clk   (push_clk),
    .pop_clk    (pop_clk),
    .rst_n      (rst_n),
    .in_a_valid (in_a_valid),
    .in_a_data  (in_a_data),
    .in_a_ready (in_a_ready),
    .in_b_valid (in_b_valid),
    .in_b_data  (in_b_data),
    .in_b_ready (in_b_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_beat   (pop_beat),
    .push_full  (push_full),
    .push_slots (push_slots),
    .pop_empty  (pop_empty),
    .pop_items  (pop_items)
  );

  // -------------------------------------------------------------------
  // Clocks, same period with pop_clk shifted by 3 ns
  // -------------------------------------------------------------------
  initial begin
    push_clk = 1'b0;
    forever #4 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    #3;
    forever #4 pop_clk = ~pop_clk;
  end

  // The nth word of a producer, source constant XOR n times an odd constant
  function automatic logic [`CDC_DATA_WIDTH-1:0] ref_payload(input src_id_e src, input int n);
    logic [31:0] scaled;
    logic [15:0] base;
    scaled = n * 32'h0000_9E37;
    base   = (src == SRC_A) ? 16'h5A3C : 16'hC3A5;
    return base ^ scaled[15:0];
  endfunction

  task automatic expect_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, name, exp, act);
    end
  endtask

  // Outputs that must sit quiet in and right after reset
  task automatic check_idle_state();
    expect_value("in_a_ready", 0, in_a_ready);
    expect_value("in_b_ready", 0, in_b_ready);
    expect_value("pop_valid", 0, pop_valid);
    expect_value("push_full", 0, push_full);
    expect_value("pop_empty", 1, pop_empty);
    expect_value("pop_items", 0, pop_items);
  endtask

  // -------------------------------------------------------------------
  // Producers on push_clk
  // -------------------------------------------------------------------
  // A producer with a pending word keeps valid and data until it is taken
  always @(posedge push_clk) begin : producers
    int na;
    int nb;
    na = sent_a + ((in_a_valid && in_a_ready) ? 1 : 0);
    nb = sent_b + ((in_b_valid && in_b_ready) ? 1 : 0);
    sent_a <= na;
    sent_b <= nb;
    if (!(in_a_valid && !in_a_ready)) begin
      if (prod_en && na < WORDS && (!rand_gate || ($random(seed) & 3) != 0)) begin
        in_a_valid <= 1'b1;
        in_a_data  <= ref_payload(SRC_A, na);
      end else begin
        in_a_valid <= 1'b0;
      end
    end
    if (!(in_b_valid && !in_b_ready)) begin
      if (prod_en && nb < WORDS && (!rand_gate || ($random(seed) & 3) != 0)) begin
        in_b_valid <= 1'b1;
        in_b_data  <= ref_payload(SRC_B, nb);
      end else begin
        in_b_valid <= 1'b0;
      end
    end
  end

  // Round robin means a tie goes to whoever did not win the last transfer
  always @(posedge push_clk) begin : fairness
    if (rst_n === 1'b1) begin
      assert (!(in_a_ready && in_b_ready)) else begin
        errors++;
        $display("Both producer readies were high together at %0t", $time);
      end
      if (in_a_ready || in_b_ready) begin
        if (in_a_valid && in_b_valid) begin
          expect_value("in_b_ready", (last_src == SRC_A), in_b_ready);
        end
        last_src = in_b_ready ? SRC_B : SRC_A;
      end
    end
  end

  // -------------------------------------------------------------------
  // Consumer and scoreboard on pop_clk
  // -------------------------------------------------------------------
  always @(posedge pop_clk) begin : consumer
    int s;
    // A stalled beat must still be there one cycle later
    if (held_check) begin
      expect_value("pop_valid", 1, pop_valid);
      expect_value("pop_beat", held_beat, pop_beat);
    end
    if (pop_valid && pop_ready) begin
      s = int'(pop_beat.src);
      assert (recv[s] < WORDS) else begin
        errors++;
        $display("Source %0d delivered a word after its last one at %0t", s, $time);
      end
      if (recv[s] < WORDS) begin
        expect_value("pop_beat.data", ref_payload(pop_beat.src, recv[s]), pop_beat.data);
      end
      recv[s] <= recv[s] + 1;
    end
    held_check = (pop_valid === 1'b1) && (pop_ready === 1'b0);
    held_beat  = pop_beat;
    if (pop_hold) begin
      pop_ready <= 1'b0;
    end else if (rand_gate) begin
      pop_ready <= (($random(seed) & 3) != 0);
    end else begin
      pop_ready <= 1'b1;
    end
  end

  // A hang anywhere ends the run here
  initial begin
    #400000;
    timeouts++;
    $display("Timeout: the simulation ran past its overall time limit");
    $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
    $display("SIMULATION FAILED");
    $finish;
  end

  // -------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------
  initial begin : main
    int cyc;
    rst_n      = 1'b0;
    in_a_valid = 1'b0;
    in_a_data  = '0;
    in_b_valid = 1'b0;
    in_b_data  = '0;
    pop_ready  = 1'b0;
    prod_en    = 1'b0;
    rand_gate  = 1'b0;
    pop_hold   = 1'b1;
    recv[0]    = 0;
    recv[1]    = 0;

    // The registered resets need a few edges before the outputs settle
    for (cyc = 0; cyc < 8; cyc++) begin
      @(posedge push_clk);
      if (cyc >= 3) begin
        check_idle_state();
      end
    end
    rst_n <= 1'b1;

    for (cyc = 0; cyc < 2; cyc++) begin
      @(posedge push_clk);
      check_idle_state();
      expect_value("push_slots", `CDC_FIFO_DEPTH, push_slots);
    end

    // Back-pressure with both producers always valid and pop_ready held low
    prod_en <= 1'b1;
    cyc = 0;
    while (!(sent_a + sent_b > 0) && cyc < START_LIMIT) begin
      @(posedge push_clk);
      cyc++;
    end
    if (!(sent_a + sent_b > 0)) begin
      timeouts++;
      $display("Timeout: no producer word was accepted after reset");
    end

    cyc = 0;
    while (!(push_full && !in_a_ready && !in_b_ready) && cyc < FULL_LIMIT) begin
      @(posedge push_clk);
      cyc++;
    end
    if (!(push_full && !in_a_ready && !in_b_ready)) begin
      timeouts++;
      $display("Timeout: the FIFO never reported full under back-pressure");
    end
    expect_value("accepted words", `CDC_FIFO_DEPTH, sent_a + sent_b);

    // Nothing more may get in while the consumer stays stalled
    for (cyc = 0; cyc < 16; cyc++) begin
      @(posedge push_clk);
      expect_value("push_full", 1, push_full);
      expect_value("in_a_ready", 0, in_a_ready);
      expect_value("in_b_ready", 0, in_b_ready);
    end
    expect_value("accepted words", `CDC_FIFO_DEPTH, sent_a + sent_b);

    // Release the consumer and switch both sides to random gating
    pop_hold  <= 1'b0;
    rand_gate <= 1'b1;
    cyc = 0;
    while (!(recv[0] >= WORDS && recv[1] >= WORDS) && cyc < RECV_LIMIT) begin
      @(posedge push_clk);
      cyc++;
    end
    if (!(recv[0] >= WORDS && recv[1] >= WORDS)) begin
      timeouts++;
      $display("Timeout: only %0d A words and %0d B words arrived", recv[0], recv[1]);
    end

    // Both sides must agree the FIFO is empty once the pointers settle
    cyc = 0;
    while (!(pop_empty && pop_items == '0 && push_slots == fifo_cnt_t'(`CDC_FIFO_DEPTH))
           && cyc < DRAIN_LIMIT) begin
      @(posedge push_clk);
      cyc++;
    end
    if (!(pop_empty && pop_items == '0 && push_slots == fifo_cnt_t'(`CDC_FIFO_DEPTH))) begin
      timeouts++;
      $display("Timeout: the FIFO counts did not return to empty after the drain");
    end
    expect_value("pop_empty", 1, pop_empty);
    expect_value("pop_items", 0, pop_items);
    expect_value("push_slots", `CDC_FIFO_DEPTH, push_slots);
    expect_value("words sent by A", WORDS, sent_a);
    expect_value("words sent by B", WORDS, sent_b);
    expect_value("words received from A", WORDS, recv[0]);
    expect_value("words received from B", WORDS, recv[1]);

    $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== cdc_mux_crossing.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

// Two producers on push_clk share one crossing into pop_clk
// The arbiter tags each word with its source and the FIFO carries it across
module cdc_mux_crossing
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
(
  input  logic                       push_clk,
  input  logic                       pop_clk,
  input  logic                       rst_n,

  // Producer A
  input  logic                       in_a_valid,
  input  logic [`CDC_DATA_WIDTH-1:0] in_a_data,
  output logic                       in_a_ready,

  // Producer B
  input  logic                       in_b_valid,
  input  logic [`CDC_DATA_WIDTH-1:0] in_b_data,
  output logic                       in_b_ready,

  // Consumer on pop_clk
  input  logic                       pop_ready,
  output logic                       pop_valid,
  output cdc_beat_t                  pop_beat,

  // Status, one pair per side
  output logic                       push_full,
  output fifo_cnt_t                  push_slots,
  output logic                       pop_empty,
  output fifo_cnt_t                  pop_items
);

  // Merged, tagged stream between the arbiter and the FIFO
  logic      push_valid;
  cdc_beat_t push_beat;
  logic      push_ready;

  cdc_push_arbiter u_arb (
    .push_clk,
    .rst_n,
    .in_a_valid,
    .in_a_data,
    .in_a_ready,
    .in_b_valid,
    .in_b_data,
    .in_b_ready,
    .push_valid,
    .push_beat,
    .push_ready
  );

  cdc_fifo_flops u_fifo (
    .push_clk,
    .pop_clk,
    .rst_n,
    .push_valid,
    .push_beat,
    .push_ready,
    .pop_ready,
    .pop_valid,
    .pop_beat,
    .push_full,
    .push_slots,
    .pop_empty,
    .pop_items
  );

endmodule

// ==== cdc_push_arbiter.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

// Round-robin merge of two producers into one tagged push stream
// Pure combinational grant, so a request is seen and granted in the same cycle
module cdc_push_arbiter
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
(
  input  logic                       push_clk,
  input  logic                       rst_n,

  input  logic                       in_a_valid,
  input  logic [`CDC_DATA_WIDTH-1:0] in_a_data,
  output logic                       in_a_ready,

  input  logic                       in_b_valid,
  input  logic [`CDC_DATA_WIDTH-1:0] in_b_data,
  output logic                       in_b_ready,

  output logic                       push_valid,
  output cdc_beat_t                  push_beat,
  input  logic                       push_ready
);

  arb_state_e prio_q;
  logic       grant_a;
  logic       grant_b;

  // A lone requester wins outright, on a tie the priority register decides
  assign grant_a = in_a_valid && (!in_b_valid || (prio_q == PRIO_A));
  assign grant_b = in_b_valid && (!in_a_valid || (prio_q == PRIO_B));

  // Valid toward the FIFO never looks at push_ready
  assign push_valid = in_a_valid || in_b_valid;

  // Only the granted producer sees the FIFO ready
  assign in_a_ready = push_ready && grant_a;
  assign in_b_ready = push_ready && grant_b;

  // Tag the winning word with its source
  always_comb begin
    if (grant_a) begin
      push_beat = '{src: SRC_A, data: in_a_data};
    end else begin
      push_beat = '{src: SRC_B, data: in_b_data};
    end
  end

  // Hand priority to the loser after every accepted word
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      prio_q <= PRIO_A;
    end else if (push_valid && push_ready) begin
      prio_q <= grant_a ? PRIO_B : PRIO_A;
    end
  end

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------

  // A producer left waiting must keep its valid and its word
  // Round robin is only fair if a stalled request is still there next cycle
  a_a_hold: assert property (@(posedge push_clk) disable iff (!rst_n)
    (in_a_valid && !in_a_ready) |=> (in_a_valid && $stable(in_a_data)));

  a_b_hold: assert property (@(posedge push_clk) disable iff (!rst_n)
    (in_b_valid && !in_b_ready) |=> (in_b_valid && $stable(in_b_data)));

endmodule

// ==== cdc_fifo_flops.sv ====
`timescale 1ns/10ps

// Asynchronous FIFO built from the pointer controller and a flop memory
// The memory write is clocked by push_clk, the read is combinational
module cdc_fifo_flops
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
(
  input  logic      push_clk,
  input  logic      pop_clk,
  input  logic      rst_n,

  input  logic      push_valid,
  input  cdc_beat_t push_beat,
  output logic      push_ready,

  input  logic      pop_ready,
  output logic      pop_valid,
  output cdc_beat_t pop_beat,

  output logic      push_full,
  output fifo_cnt_t push_slots,
  output logic      pop_empty,
  output fifo_cnt_t pop_items
);

  // Memory port between the controller and the flops
  logic       ram_wr_en;
  fifo_addr_t ram_wr_addr;
  cdc_beat_t  ram_wr_beat;
  fifo_addr_t ram_rd_addr;
  cdc_beat_t  ram_rd_beat;

  cdc_fifo_ctrl u_ctrl (
    .push_clk,
    .pop_clk,
    .rst_n,
    .push_valid,
    .push_beat,
    .push_ready,
    .pop_ready,
    .pop_valid,
    .pop_beat,
    .push_full,
    .push_slots,
    .pop_empty,
    .pop_items,
    .ram_wr_en,
    .ram_wr_addr,
    .ram_wr_beat,
    .ram_rd_addr,
    .ram_rd_beat
  );

  cdc_ram_flops u_ram (
    .wr_clk  (push_clk),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_beat (ram_wr_beat),
    .rd_addr (ram_rd_addr),
    .rd_beat (ram_rd_beat)
  );

endmodule

// ==== cdc_fifo_ctrl.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

// Pointer, flag and count logic of the asynchronous FIFO
// The write side lives on push_clk, the read side on pop_clk
module cdc_fifo_ctrl
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
(
  input  logic       push_clk,
  input  logic       pop_clk,
  input  logic       rst_n,

  input  logic       push_valid,
  input  cdc_beat_t  push_beat,
  output logic       push_ready,

  input  logic       pop_ready,
  output logic       pop_valid,
  output cdc_beat_t  pop_beat,

  output logic       push_full,
  output fifo_cnt_t  push_slots,
  output logic       pop_empty,
  output fifo_cnt_t  pop_items,

  output logic       ram_wr_en,
  output fifo_addr_t ram_wr_addr,
  output cdc_beat_t  ram_wr_beat,
  output fifo_addr_t ram_rd_addr,
  input  cdc_beat_t  ram_rd_beat
);

  localparam int PTR_W = $bits(fifo_ptr_t);

  logic      push_rst_n_q;
  logic      pop_rst_n_q;
  logic      push_up_q;
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t wr_gray_q;
  fifo_ptr_t rd_ptr_q;
  fifo_ptr_t rd_gray_q;
  fifo_ptr_t wr_gray_sync;
  fifo_ptr_t rd_gray_sync;
  fifo_ptr_t push_used;
  fifo_ptr_t ram_items;
  logic      ram_valid;
  fifo_ptr_t fetch_ptr;
  logic      pop_done;

  function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
    fifo_ptr_t b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // Each domain takes its own registered copy of the reset
  always_ff @(posedge push_clk) begin
    push_rst_n_q <= rst_n;
  end

  always_ff @(posedge pop_clk) begin
    pop_rst_n_q <= rst_n;
  end

  // -------------------------------------------------------------------
  // Push side
  // -------------------------------------------------------------------

  // Occupancy as the push side sees it, stale by the synchronizer depth
  assign push_used  = wr_ptr_q - gray2bin(rd_gray_sync);
  assign push_full  = (push_used == fifo_ptr_t'(`CDC_FIFO_DEPTH));
  assign push_slots = fifo_cnt_t'(`CDC_FIFO_DEPTH) - fifo_cnt_t'(push_used);
  // Ready comes up one cycle after the local reset lets go
  assign push_ready = push_up_q && !push_full;

  assign ram_wr_en   = push_valid && push_ready;
  assign ram_wr_addr = wr_ptr_q[FIFO_ADDR_W-1:0];
  assign ram_wr_beat = push_beat;

  // Gray copy is a register so the crossing never sees a glitch
  always_ff @(posedge push_clk) begin
    if (!push_rst_n_q) begin
      push_up_q <= 1'b0;
      wr_ptr_q  <= '0;
      wr_gray_q <= '0;
    end else begin
      push_up_q <= 1'b1;
      if (ram_wr_en) begin
        wr_ptr_q  <= wr_ptr_q + 1'b1;
        wr_gray_q <= bin2gray(wr_ptr_q + 1'b1);
      end
    end
  end

  cdc_gray_sync #(.PTR_W(PTR_W)) u_rd_sync (
    .dst_clk   (push_clk),
    .rst_n_dst (push_rst_n_q),
    .gray_in   (rd_gray_q),
    .gray_out  (rd_gray_sync)
  );

  // -------------------------------------------------------------------
  // Pop side
  // -------------------------------------------------------------------

  cdc_gray_sync #(.PTR_W(PTR_W)) u_wr_sync (
    .dst_clk   (pop_clk),
    .rst_n_dst (pop_rst_n_q),
    .gray_in   (wr_gray_q),
    .gray_out  (wr_gray_sync)
  );

  // Entries still sitting in the RAM, not counting a staged output beat
  assign ram_items   = gray2bin(wr_gray_sync) - fetch_ptr;
  assign ram_valid   = (ram_items != '0);
  assign ram_rd_addr = fetch_ptr[FIFO_ADDR_W-1:0];

  // The read pointer counts beats handed out at the pop port
  // A beat parked in the output stage still holds its entry for push_clk
  assign pop_done = pop_valid && pop_ready;

  always_ff @(posedge pop_clk) begin
    if (!pop_rst_n_q) begin
      rd_ptr_q  <= '0;
      rd_gray_q <= '0;
    end else if (pop_done) begin
      rd_ptr_q  <= rd_ptr_q + 1'b1;
      rd_gray_q <= bin2gray(rd_ptr_q + 1'b1);
    end
  end

  if (`CDC_REG_POP_OUT != 0) begin : g_pop_reg
    logic      out_valid_q;
    cdc_beat_t out_beat_q;
    logic      ram_pop;

    // A staged beat sits one entry ahead of the read pointer
    assign fetch_ptr = rd_ptr_q + fifo_ptr_t'(out_valid_q);

    // Refill the stage when empty or when its beat leaves this cycle
    assign ram_pop = ram_valid && (!out_valid_q || pop_ready);

    always_ff @(posedge pop_clk) begin
      if (!pop_rst_n_q) begin
        out_valid_q <= 1'b0;
      end else if (ram_pop) begin
        out_valid_q <= 1'b1;
      end else if (pop_ready) begin
        out_valid_q <= 1'b0;
      end
    end

    always_ff @(posedge pop_clk) begin
      if (ram_pop) begin
        out_beat_q <= ram_rd_beat;
      end
    end

    assign pop_valid = out_valid_q;
    assign pop_beat  = out_beat_q;
    assign pop_items = fifo_cnt_t'(ram_items) + fifo_cnt_t'(out_valid_q);
  end else begin : g_pop_comb
    // The read address only moves on a pop, so the beat holds under stall
    assign fetch_ptr = rd_ptr_q;
    assign pop_valid = ram_valid;
    assign pop_beat  = ram_rd_beat;
    assign pop_items = fifo_cnt_t'(ram_items);
  end

  assign pop_empty = (pop_items == '0);

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------

  // A write never pushes the pointer more than the depth past the read side
  a_no_overrun: assert property (@(posedge push_clk) disable iff (!push_rst_n_q)
    ram_wr_en |=> (push_used <= fifo_ptr_t'(`CDC_FIFO_DEPTH)));

endmodule

// ==== cdc_ram_flops.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

// -------------------------------------------------------------------
// One write port, one read port flop memory
// -------------------------------------------------------------------
// Written on the push clock edge and read without a clock from the pop side
// The read side only ever looks at entries the pointers mark as filled,
// and those are stable by the time the write pointer has crossed over
module cdc_ram_flops
  import cdc_beat_pkg::*, cdc_ctrl_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_en,
  input  fifo_addr_t wr_addr,
  input  cdc_beat_t  wr_beat,

  input  fifo_addr_t rd_addr,
  output cdc_beat_t  rd_beat
);

  // Storage array, one tagged beat per FIFO entry
  cdc_beat_t mem [`CDC_FIFO_DEPTH];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_beat;
    end
  end

  // Read port has zero latency
  // A plain mux is enough since the addressed entry is not being written
  assign rd_beat = mem[rd_addr];

endmodule

// ==== cdc_gray_sync.sv ====
`timescale 1ns/10ps
`include "cdc_fifo_defs.svh"

// Brings a Gray-coded pointer into the destination clock domain
// Only one bit moves per step, so a sample caught mid-change is either the
// old or the new pointer value and never a mix of both
module cdc_gray_sync #(
  parameter int PTR_W = 4
) (
  input  logic             dst_clk,
  input  logic             rst_n_dst,
  input  logic [PTR_W-1:0] gray_in,
  output logic [PTR_W-1:0] gray_out
);

  localparam int STAGES = `CDC_SYNC_STAGES;

  // Stage 0 is the flop that may go metastable
  // The later stages give it time to settle before anyone reads it
  logic [STAGES-1:0][PTR_W-1:0] sync_q;

  always_ff @(posedge dst_clk) begin
    if (!rst_n_dst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], gray_in};
    end
  end

  assign gray_out = sync_q[STAGES-1];

  // -------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------

  // The source pointer must step by at most one Gray code per sample here
  // This holds while the source clock is no faster than dst_clk
  a_gray_step: assert property (@(posedge dst_clk) disable iff (!rst_n_dst)
    $countones(gray_in ^ $past(gray_in)) <= 1);

endmodule

// ==== cdc_ctrl_pkg.sv ====
`include "cdc_fifo_defs.svh"

// -------------------------------------------------------------------
// Control types for the arbiter and the FIFO pointers
// -------------------------------------------------------------------
package cdc_ctrl_pkg;

  // Producer that wins the next tie
  typedef enum logic {
    PRIO_A = 1'b0,
    PRIO_B = 1'b1
  } arb_state_e;

  localparam int FIFO_ADDR_W = $clog2(`CDC_FIFO_DEPTH);

  // RAM index, the low bits of a pointer
  typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
  // Pointer with one extra wrap bit to tell full from empty
  typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;
  // Fill or free count, 0 up to the depth
  typedef logic [$clog2(`CDC_FIFO_DEPTH + 1)-1:0] fifo_cnt_t;

endpackage

// ==== cdc_beat_pkg.sv ====
`include "cdc_fifo_defs.svh"

// -------------------------------------------------------------------
// Payload types that travel from the push domain to the pop domain
// -------------------------------------------------------------------
package cdc_beat_pkg;

  // Which producer a word came from
  // The single tag bit lets both producers share one FIFO storage
  typedef enum logic {
    SRC_A = 1'b0,
    SRC_B = 1'b1
  } src_id_e;

  // One stored entry, tag in the top bit and the word below it
  // The RAM holds these and the pop port hands them out unchanged
  typedef struct packed {
    src_id_e                     src;
    logic [`CDC_DATA_WIDTH-1:0]  data;
  } cdc_beat_t;

endpackage

// ==== cdc_fifo_defs.svh ====
`ifndef CDC_FIFO_DEFS_SVH
`define CDC_FIFO_DEFS_SVH

// Build-time knobs for the two-source clock crossing channel

// Number of FIFO entries
// Must be a power of two and at least 2 so the wrap bit scheme holds
`define CDC_FIFO_DEPTH 8

// Width of one producer word, not counting the source tag
`define CDC_DATA_WIDTH 16

// Flops per pointer synchronizer, 2 or more
`define CDC_SYNC_STAGES 3

// Set to 1 to put a register stage in front of the pop outputs
// This costs one pop_clk cycle of cut-through latency
`define CDC_REG_POP_OUT 1

`endif
